// File: rtl/board_regs.sv
// ----------------------------------------------------------------------
// board registers, channel 0
// ip address and watchdog code registers, the watchdog timer and the
// channel 0 read mux
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module board_regs import host_bus_pkg::*; #(
    parameter logic [15:0] WDOG_UNIT = 16'd50000   // sysclk cycles per code step
) (
    input  logic       sysclk,
    input  logic       reset,
    input  logic [3:0] board_id,          // rotary switch
    input  addr_t      reg_raddr,
    input  addr_t      reg_waddr,
    input  data_t      reg_wdata,
    input  logic       reg_wen,
    input  data_t      prom_status,
    input  data_t      prom_result,
    input  data_t      eth_result,
    input  data_t      reg_rdata_ext,
    input  logic       wdog_clear,        // drop timeout flag
    output data_t      chan0_rdata,
    output data_t      ip_address,
    output logic       wdog_period_led,
    output wdog_code_t wdog_period_status,
    output logic       wdog_timeout
);

    wdog_state_t wdog_state;
    wdog_code_t  wdog_code;
    logic [18:0] wdog_count;   // cycles since last host write
    logic [18:0] wdog_limit;   // code * unit
    logic        ip_wen;
    logic        wdog_wen;

    // write decode on the arbitrated bus, channel 0 only
    assign ip_wen   = reg_wen && (reg_waddr == {ADDR_MAIN, 8'h00, REG_IPADDR});
    assign wdog_wen = reg_wen && (reg_waddr == {ADDR_MAIN, 8'h00, REG_WDOG});
    assign wdog_limit = 19'(wdog_code) * 19'(WDOG_UNIT);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            ip_address <= IP_RESET_VALUE;
        end else if (ip_wen) begin
            ip_address <= reg_wdata;
        end
    end

    // ------------------------------------------------------------------
    // watchdog timer
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_state   <= WDOG_OFF;
            wdog_code    <= '0;
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_wen) begin
            wdog_code  <= reg_wdata[2:0];
            wdog_count <= '0;
            if (reg_wdata[2:0] == 3'd0) begin
                wdog_state   <= WDOG_OFF;    // disabling also clears the flag
                wdog_timeout <= 1'b0;
            end else begin
                wdog_state <= WDOG_RUN;
            end
        end else begin
            if (wdog_clear) begin
                wdog_timeout <= 1'b0;
            end
            case (wdog_state)
                WDOG_RUN: begin
                    if (reg_wen) begin
                        wdog_count <= '0;                 // host is alive
                    end else if (wdog_count + 19'd1 >= wdog_limit) begin
                        wdog_state   <= WDOG_EXPIRED;     // count reaches the limit
                        wdog_timeout <= 1'b1;
                        wdog_count   <= wdog_count + 19'd1;
                    end else begin
                        wdog_count <= wdog_count + 19'd1;
                    end
                end
                WDOG_EXPIRED: begin
                    if (wdog_clear) begin
                        wdog_state <= (wdog_code == 3'd0) ? WDOG_OFF : WDOG_RUN;
                        wdog_count <= '0;
                    end
                end
                default: wdog_count <= '0;                // off, hold at zero
            endcase
        end
    end

    assign wdog_period_status = wdog_code;
    assign wdog_period_led    = |wdog_code;               // lit while enabled

    // channel 0 read mux, channel already decoded by the router
    always_comb begin
        case (reg_raddr[3:0])
            REG_STATUS:   chan0_rdata = {wdog_timeout, 3'd0, board_id, 24'd0};
            REG_WDOG:     chan0_rdata = {29'd0, wdog_code};
            REG_IPADDR:   chan0_rdata = ip_address;
            REG_PROMSTAT: chan0_rdata = prom_status;
            REG_PROMRES:  chan0_rdata = prom_result;
            REG_ETHRES:   chan0_rdata = eth_result;
            default:      chan0_rdata = reg_rdata_ext;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fpga_bus_core.sv
// ----------------------------------------------------------------------
// fpga bus core
// shared register bus fabric between the host-link masters and the
// board registers
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fpga_bus_core import host_bus_pkg::*; #(
    parameter logic [15:0] WDOG_UNIT = 16'd50000   // watchdog step in sysclk cycles
) (
    input  logic         sysclk,
    input  logic         reset,
    input  logic [3:0]   board_id,
    // block write engine
    input  logic         bw_write_en,
    input  logic         bw_reg_wen,
    input  logic         bw_blk_wen,
    input  logic         bw_blk_wstart,
    input  logic [7:0]   bw_reg_waddr,
    input  data_t        bw_reg_wdata,
    // ethernet master
    input  logic         eth_write_en,
    input  logic         eth_reg_wen,
    input  logic         eth_blk_wen,
    input  logic         eth_blk_wstart,
    input  addr_t        eth_reg_waddr,
    input  data_t        eth_reg_wdata,
    input  logic         eth_read_en,
    input  addr_t        eth_reg_raddr,
    // firewire master
    input  logic         fw_reg_wen,
    input  logic         fw_blk_wen,
    input  logic         fw_blk_wstart,
    input  addr_t        fw_reg_waddr,
    input  data_t        fw_reg_wdata,
    input  addr_t        fw_reg_raddr,
    // real-time write sources
    input  logic         eth_rt_wen,
    input  logic         fw_rt_wen,
    input  rt_addr_t     eth_rt_waddr,
    input  rt_addr_t     fw_rt_waddr,
    input  data_t        eth_rt_wdata,
    input  data_t        fw_rt_wdata,
    // data sampler
    input  logic         sample_busy,
    input  chan_t        sample_chan,
    input  logic         eth_sample_start,
    input  logic         fw_sample_start,
    input  logic         eth_sample_read,
    input  sample_addr_t eth_sample_raddr,
    input  sample_addr_t fw_sample_raddr,
    // read sources
    input  data_t        hub_rdata,
    input  data_t        prom_rdata,
    input  data_t        eth_io_rdata,
    input  data_t        eth_mac_rdata,
    input  data_t        fw_rdata,
    input  data_t        reg_rdata_ext,
    input  data_t        prom_status,
    input  data_t        prom_result,
    input  data_t        eth_result,
    input  logic         wdog_clear,
    // arbitrated buses
    output logic         reg_wen,
    output logic         blk_wen,
    output logic         blk_wstart,
    output addr_t        reg_waddr,
    output data_t        reg_wdata,
    output logic         rt_wen,
    output rt_addr_t     rt_waddr,
    output data_t        rt_wdata,
    output addr_t        reg_raddr,
    output data_t        reg_rdata,
    output logic         sample_start,
    output sample_addr_t sample_raddr,
    output data_t        ip_address,
    output logic         wdog_period_led,
    output wdog_code_t   wdog_period_status,
    output logic         wdog_timeout
);

    data_t chan0_rdata;   // board register read data into the router

    // ------------------------------------------------------------------
    // fabric blocks, port names match the nets one to one
    // ------------------------------------------------------------------
    write_bus_arbiter i_write_bus_arbiter (.*);   // drives write bus and rt port

    read_bus_select i_read_bus_select (.*);       // drives reg_raddr and sampling

    read_data_router i_read_data_router (.*);     // drives reg_rdata

    board_regs #(
        .WDOG_UNIT(WDOG_UNIT)
    ) i_board_regs (.*);                          // fed by the arbitrated write bus

endmodule

`default_nettype wire

// File: rtl/host_bus_pkg.sv
// ----------------------------------------------------------------------
// host bus package
// shared widths, address-space codes, board register offsets and the
// watchdog state type for the register-bus fabric
// ----------------------------------------------------------------------
`default_nettype none

package host_bus_pkg;

    // ------------------------------------------------------------------
    // bus field types
    // ------------------------------------------------------------------
    typedef logic [15:0] addr_t;          // register bus address
    typedef logic [31:0] data_t;          // register bus data
    typedef logic [3:0]  space_t;         // address space, addr[15:12]
    typedef logic [3:0]  reg_off_t;       // register offset within a channel
    typedef logic [3:0]  chan_t;          // sampler channel
    typedef logic [3:0]  rt_addr_t;       // real-time write address
    typedef logic [5:0]  sample_addr_t;   // sample buffer address
    typedef logic [2:0]  wdog_code_t;     // watchdog period code

    // address spaces
    localparam space_t ADDR_MAIN = 4'd0;  // board and channel registers
    localparam space_t ADDR_HUB  = 4'd2;  // hub memory
    localparam space_t ADDR_PROM = 4'd3;  // prom block reads
    localparam space_t ADDR_ETH  = 4'd4;  // ethernet memory
    localparam space_t ADDR_FW   = 4'd5;  // firewire packet memory

    // channel 0 register offsets
    localparam reg_off_t REG_STATUS   = 4'd0;   // board status
    localparam reg_off_t REG_WDOG     = 4'd3;   // watchdog period code
    localparam reg_off_t REG_PROMSTAT = 4'd8;   // prom status
    localparam reg_off_t REG_PROMRES  = 4'd9;   // prom result
    localparam reg_off_t REG_IPADDR   = 4'd11;  // board ip address
    localparam reg_off_t REG_ETHRES   = 4'd12;  // ethernet result

    localparam data_t IP_RESET_VALUE = 32'hFFFF_FFFF;  // no address assigned

    // watchdog timer states
    typedef enum logic [1:0] {
        WDOG_OFF,       // period code zero, timer idle
        WDOG_RUN,       // counting since last host write
        WDOG_EXPIRED    // timed out, waiting for clear
    } wdog_state_t;

endpackage

`default_nettype wire

// File: rtl/read_bus_select.sv
// ----------------------------------------------------------------------
// read bus select
// read address ownership (sampler, ethernet, firewire), sample buffer
// reader select and start gating while sampling
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module read_bus_select import host_bus_pkg::*; (
    input  logic         sample_busy,       // sampler owns the read address
    input  chan_t        sample_chan,       // channel being sampled
    input  logic         eth_read_en,       // ethernet owns the read address
    input  addr_t        eth_reg_raddr,
    input  addr_t        fw_reg_raddr,
    input  logic         eth_sample_start,
    input  logic         fw_sample_start,
    input  logic         eth_sample_read,   // ethernet reads the sample buffer
    input  sample_addr_t eth_sample_raddr,
    input  sample_addr_t fw_sample_raddr,
    output addr_t        reg_raddr,
    output sample_addr_t sample_raddr,
    output logic         sample_start
);

    addr_t sampler_raddr;  // offset 0 of the sampled channel

    assign sampler_raddr = {ADDR_MAIN, 4'd0, sample_chan, 4'd0};

    // ------------------------------------------------------------------
    // read address priority
    // ------------------------------------------------------------------
    always_comb begin
        if (sample_busy) begin
            reg_raddr = sampler_raddr;    // sampler first
        end else if (eth_read_en) begin
            reg_raddr = eth_reg_raddr;
        end else begin
            reg_raddr = fw_reg_raddr;     // firewire by default
        end
    end

    assign sample_raddr = eth_sample_read ? eth_sample_raddr : fw_sample_raddr;

    // a request during sampling is dropped, not queued
    assign sample_start = (eth_sample_start | fw_sample_start) & ~sample_busy;

endmodule

`default_nettype wire

// File: rtl/read_data_router.sv
// ----------------------------------------------------------------------
// read data router
// returns the read data of the block that owns the addressed space,
// the external board is the default source
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module read_data_router import host_bus_pkg::*; (
    input  addr_t reg_raddr,
    input  data_t hub_rdata,       // hub memory
    input  data_t prom_rdata,      // prom block reads
    input  data_t eth_io_rdata,    // ethernet io memory
    input  data_t eth_mac_rdata,   // ethernet mac registers
    input  data_t fw_rdata,        // firewire packet memory
    input  data_t chan0_rdata,     // board registers
    input  data_t reg_rdata_ext,   // external board
    output data_t reg_rdata
);

    space_t raddr_space;   // addr[15:12]
    chan_t  raddr_chan;    // addr[7:4]
    logic   is_chan0;      // main space, board channel

    assign raddr_space = reg_raddr[15:12];
    assign raddr_chan  = reg_raddr[7:4];
    assign is_chan0    = (raddr_space == ADDR_MAIN) && (raddr_chan == 4'd0);

    always_comb begin
        case (raddr_space)
            ADDR_HUB:  reg_rdata = hub_rdata;
            ADDR_PROM: reg_rdata = prom_rdata;
            ADDR_ETH:  reg_rdata = eth_io_rdata | eth_mac_rdata;  // idle side reads zero
            ADDR_FW:   reg_rdata = fw_rdata;
            default: begin
                if (is_chan0) begin
                    reg_rdata = chan0_rdata;
                end else begin
                    reg_rdata = reg_rdata_ext;   // motor channels and the rest
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/write_bus_arbiter.sv
// ----------------------------------------------------------------------
// write bus arbiter
// fixed priority mux of the register write bus (block write, ethernet,
// firewire) and of the real-time write port (ethernet, firewire)
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module write_bus_arbiter import host_bus_pkg::*; (
    input  logic       bw_write_en,       // block write engine owns the bus
    input  logic       bw_reg_wen,
    input  logic       bw_blk_wen,
    input  logic       bw_blk_wstart,
    input  logic [7:0] bw_reg_waddr,      // short address, main space only
    input  data_t      bw_reg_wdata,
    input  logic       eth_write_en,      // ethernet owns the bus
    input  logic       eth_reg_wen,
    input  logic       eth_blk_wen,
    input  logic       eth_blk_wstart,
    input  addr_t      eth_reg_waddr,
    input  data_t      eth_reg_wdata,
    input  logic       fw_reg_wen,
    input  logic       fw_blk_wen,
    input  logic       fw_blk_wstart,
    input  addr_t      fw_reg_waddr,
    input  data_t      fw_reg_wdata,
    input  logic       eth_rt_wen,
    input  logic       fw_rt_wen,
    input  rt_addr_t   eth_rt_waddr,
    input  rt_addr_t   fw_rt_waddr,
    input  data_t      eth_rt_wdata,
    input  data_t      fw_rt_wdata,
    output logic       reg_wen,
    output logic       blk_wen,
    output logic       blk_wstart,
    output addr_t      reg_waddr,
    output data_t      reg_wdata,
    output logic       rt_wen,
    output rt_addr_t   rt_waddr,
    output data_t      rt_wdata
);

    // ------------------------------------------------------------------
    // register write bus, whole bundle from one master
    // ------------------------------------------------------------------
    always_comb begin
        if (bw_write_en) begin                  // real-time block write first
            reg_wen    = bw_reg_wen;
            blk_wen    = bw_blk_wen;
            blk_wstart = bw_blk_wstart;
            reg_waddr  = {8'd0, bw_reg_waddr};  // zero extend
            reg_wdata  = bw_reg_wdata;
        end else if (eth_write_en) begin
            reg_wen    = eth_reg_wen;
            blk_wen    = eth_blk_wen;
            blk_wstart = eth_blk_wstart;
            reg_waddr  = eth_reg_waddr;
            reg_wdata  = eth_reg_wdata;
        end else begin                          // firewire is the default owner
            reg_wen    = fw_reg_wen;
            blk_wen    = fw_blk_wen;
            blk_wstart = fw_blk_wstart;
            reg_waddr  = fw_reg_waddr;
            reg_wdata  = fw_reg_wdata;
        end
    end

    // real-time port, ethernet wins while it strobes
    assign rt_wen   = eth_rt_wen ? eth_rt_wen   : fw_rt_wen;
    assign rt_waddr = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;
    assign rt_wdata = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;

endmodule

`default_nettype wire

// File: verif/fpga_bus_core_assert.sv
// ----------------------------------------------------------------------
// fpga bus core assertions
// protocol rules of the register bus fabric, bound to the top level
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fpga_bus_core_assert import host_bus_pkg::*; (
    input logic       sysclk,
    input logic       reset,
    input logic       sample_busy,
    input logic       sample_start,
    input logic       bw_write_en,
    input addr_t      reg_waddr,
    input logic       eth_rt_wen,
    input logic       fw_rt_wen,
    input logic       rt_wen,
    input wdog_code_t wdog_period_status,
    input logic       wdog_timeout
);

    // no sampling start while the sampler runs
    a_start_gated: assert property (@(posedge sysclk) disable iff (reset)
        sample_busy |-> !sample_start)
        else $error("sample start raised while sampler busy");

    // block write addresses are 8 bits, zero extended
    a_bw_zero_ext: assert property (@(posedge sysclk) disable iff (reset)
        bw_write_en |-> (reg_waddr[15:8] == 8'h00))
        else $error("upper address byte set during block write");

    a_rt_wen: assert property (@(posedge sysclk) disable iff (reset)
        rt_wen == (eth_rt_wen | fw_rt_wen))
        else $error("real-time write enable lost or invented");

    // a disabled watchdog never times out
    a_wdog_off: assert property (@(posedge sysclk) disable iff (reset)
        (wdog_period_status == 3'd0) |-> !wdog_timeout)
        else $error("watchdog timeout with period code zero");

endmodule

bind fpga_bus_core fpga_bus_core_assert i_assert (.*);

`default_nettype wire

// File: verif/tb_fpga_bus_core.sv
// ----------------------------------------------------------------------
// fpga bus core testbench
// table driven checks of write arbitration, read selection, space
// routing, board registers and the watchdog timer
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_bus_core import host_bus_pkg::*; ();

    localparam logic [15:0] WDOG_UNIT = 16'd8;   // short watchdog step

    logic         sysclk = 1'b0;
    logic         reset;
    logic [3:0]   board_id;
    logic         bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart;
    logic [7:0]   bw_reg_waddr;
    data_t        bw_reg_wdata;
    logic         eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_read_en;
    addr_t        eth_reg_waddr, eth_reg_raddr;
    data_t        eth_reg_wdata;
    logic         fw_reg_wen, fw_blk_wen, fw_blk_wstart;
    addr_t        fw_reg_waddr, fw_reg_raddr;
    data_t        fw_reg_wdata;
    logic         eth_rt_wen, fw_rt_wen;
    rt_addr_t     eth_rt_waddr, fw_rt_waddr;
    data_t        eth_rt_wdata, fw_rt_wdata;
    logic         sample_busy, eth_sample_start, fw_sample_start, eth_sample_read;
    chan_t        sample_chan;
    sample_addr_t eth_sample_raddr, fw_sample_raddr;
    data_t        hub_rdata, prom_rdata, eth_io_rdata, eth_mac_rdata, fw_rdata;
    data_t        reg_rdata_ext, prom_status, prom_result, eth_result;
    logic         wdog_clear;
    logic         reg_wen, blk_wen, blk_wstart, rt_wen, sample_start;
    addr_t        reg_waddr, reg_raddr;
    data_t        reg_wdata, rt_wdata, reg_rdata, ip_address;
    rt_addr_t     rt_waddr;
    sample_addr_t sample_raddr;
    logic         wdog_period_led, wdog_timeout;
    wdog_code_t   wdog_period_status;

    integer       seed = 53;
    int           errors = 0;
    int           checks = 0;

    // write bundles per source, index 0 block write, 1 ethernet, 2 firewire
    logic [2:0]   strobe_src [3];                  // {reg_wen, blk_wen, blk_wstart}
    addr_t        waddr_src [3];
    data_t        wdata_src [3];

    // {bw_write_en, eth_write_en, eth_rt_wen, sample_busy, eth_read_en, eth_sample_read}
    logic [5:0]   enable_table [8] = '{6'b000_000, 6'b001_101, 6'b010_011, 6'b011_110,
                                       6'b100_001, 6'b101_111, 6'b110_010, 6'b111_100};

    fpga_bus_core #(
        .WDOG_UNIT(WDOG_UNIT)
    ) i_dut (.*);

    always #50 sysclk = ~sysclk;                   // 100 ns period

    // ------------------------------------------------------------------
    // helpers, each starts and ends on a falling edge
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic idle_inputs();
        {bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart} = '0;
        bw_reg_waddr = '0;
        bw_reg_wdata = '0;
        {eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_read_en} = '0;
        {eth_reg_waddr, eth_reg_raddr, eth_reg_wdata} = '0;
        {fw_reg_wen, fw_blk_wen, fw_blk_wstart} = '0;
        {fw_reg_waddr, fw_reg_raddr, fw_reg_wdata} = '0;
        {eth_rt_wen, fw_rt_wen, eth_rt_waddr, fw_rt_waddr} = '0;
        {eth_rt_wdata, fw_rt_wdata} = '0;
        {sample_busy, eth_sample_start, fw_sample_start, eth_sample_read} = '0;
        {sample_chan, eth_sample_raddr, fw_sample_raddr} = '0;
        {hub_rdata, prom_rdata, eth_io_rdata, eth_mac_rdata, fw_rdata} = '0;
        {reg_rdata_ext, prom_status, prom_result, eth_result} = '0;
        wdog_clear = 1'b0;
        board_id = 4'h0;
    endtask

    // one firewire register write, sampled on the rising edge in between
    task automatic bus_write(input addr_t addr, input data_t data);
        fw_reg_wen = 1'b1;
        fw_reg_waddr = addr;
        fw_reg_wdata = data;
        @(negedge sysclk);
        fw_reg_wen = 1'b0;
    endtask

    task automatic read_check(input addr_t addr, input data_t exp, input string name);
        fw_reg_raddr = addr;                       // firewire owns the read bus when idle
        #1;
        check_value($sformatf("reg_rdata %s", name), reg_rdata, exp);
        @(negedge sysclk);
    endtask

    initial begin
        int    row;
        int    src;
        int    win;
        int    space;
        int    n;
        addr_t raddr;
        addr_t exp_addr;
        data_t exp_data;
        data_t ip_value;

        idle_inputs();
        reset = 1'b1;
        repeat (4) @(negedge sysclk);              // four rising edges in reset
        reset = 1'b0;
        board_id = 4'hA;
        #1;
        check_value("wdog_period_led", wdog_period_led, 1'b0);
        check_value("wdog_period_status", wdog_period_status, 3'd0);
        check_value("wdog_timeout", wdog_timeout, 1'b0);
        check_value("ip_address", ip_address, IP_RESET_VALUE);
        @(negedge sysclk);
        read_check({ADDR_MAIN, 8'h00, REG_IPADDR}, IP_RESET_VALUE, "ip reset read");

        // --------------------------------------------------------------
        // write priority and read selection from the enable table
        // --------------------------------------------------------------
        for (row = 0; row < 8; row++) begin
            {bw_write_en, eth_write_en, eth_rt_wen,
             sample_busy, eth_read_en, eth_sample_read} = enable_table[row];
            for (src = 0; src < 3; src++) begin
                strobe_src[src] = 3'($random(seed));
                waddr_src[src] = 16'($random(seed)) | 16'h0080;   // never channel 0
                wdata_src[src] = $random(seed);
            end
            {bw_reg_wen, bw_blk_wen, bw_blk_wstart} = strobe_src[0];
            bw_reg_waddr = waddr_src[0][7:0];
            bw_reg_wdata = wdata_src[0];
            {eth_reg_wen, eth_blk_wen, eth_blk_wstart} = strobe_src[1];
            eth_reg_waddr = waddr_src[1];
            eth_reg_wdata = wdata_src[1];
            {fw_reg_wen, fw_blk_wen, fw_blk_wstart} = strobe_src[2];
            fw_reg_waddr = waddr_src[2];
            fw_reg_wdata = wdata_src[2];
            fw_rt_wen = row[1];                    // all four rt enable pairs
            {eth_rt_waddr, fw_rt_waddr} = 8'($random(seed));
            eth_rt_wdata = $random(seed);
            fw_rt_wdata = $random(seed);
            sample_chan = 4'($random(seed));
            eth_reg_raddr = 16'($random(seed));
            fw_reg_raddr = 16'($random(seed));
            {eth_sample_start, fw_sample_start} = 2'(row % 3 + 1);  // always a request
            {eth_sample_raddr, fw_sample_raddr} = 12'($random(seed));
            #1;
            win = bw_write_en ? 0 : (eth_write_en ? 1 : 2);      // fixed priority
            exp_addr = (win == 0) ? {8'h00, waddr_src[0][7:0]} : waddr_src[win];
            check_value("reg_wen", reg_wen, strobe_src[win][2]);
            check_value("blk_wen", blk_wen, strobe_src[win][1]);
            check_value("blk_wstart", blk_wstart, strobe_src[win][0]);
            check_value("reg_waddr", reg_waddr, exp_addr);
            check_value("reg_wdata", reg_wdata, wdata_src[win]);
            check_value("rt_wen", rt_wen, eth_rt_wen | fw_rt_wen);
            check_value("rt_waddr", rt_waddr, eth_rt_wen ? eth_rt_waddr : fw_rt_waddr);
            check_value("rt_wdata", rt_wdata, eth_rt_wen ? eth_rt_wdata : fw_rt_wdata);
            if (sample_busy) begin
                exp_addr = {ADDR_MAIN, 4'h0, sample_chan, 4'h0};  // sampled channel
            end else begin
                exp_addr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;
            end
            check_value("reg_raddr", reg_raddr, exp_addr);
            check_value("sample_raddr", sample_raddr,
                        eth_sample_read ? eth_sample_raddr : fw_sample_raddr);
            check_value("sample_start", sample_start,
                        (eth_sample_start | fw_sample_start) & ~sample_busy);
            @(negedge sysclk);
        end
        idle_inputs();
        board_id = 4'hA;

        // --------------------------------------------------------------
        // read data routing over all sixteen spaces
        // --------------------------------------------------------------
        hub_rdata = $random(seed);
        prom_rdata = $random(seed);
        eth_io_rdata = $random(seed);
        eth_mac_rdata = $random(seed);
        fw_rdata = $random(seed);
        reg_rdata_ext = $random(seed);
        for (space = 0; space < 16; space++) begin
            raddr = {4'(space), 12'($random(seed))};
            if (space == 0) begin
                raddr[7:4] = 4'h6;                 // main space, motor channel
            end
            case (4'(space))
                ADDR_HUB:  exp_data = hub_rdata;
                ADDR_PROM: exp_data = prom_rdata;
                ADDR_ETH:  exp_data = eth_io_rdata | eth_mac_rdata;
                ADDR_FW:   exp_data = fw_rdata;
                default:   exp_data = reg_rdata_ext;
            endcase
            read_check(raddr, exp_data, "space routing");
        end

        // --------------------------------------------------------------
        // channel 0 registers
        // --------------------------------------------------------------
        read_check({ADDR_MAIN, 8'h00, REG_STATUS}, {8'h0A, 24'h0}, "status read");
        ip_value = $random(seed);
        bus_write({ADDR_MAIN, 8'h00, REG_IPADDR}, ip_value);
        read_check({ADDR_MAIN, 8'h00, REG_IPADDR}, ip_value, "ip readback");
        bus_write(16'h001B, ~ip_value);            // same offset in channel 1
        read_check({ADDR_MAIN, 8'h00, REG_IPADDR}, ip_value, "ip after neighbor write");
        prom_status = $random(seed);
        prom_result = $random(seed);
        eth_result = $random(seed);
        read_check({ADDR_MAIN, 8'h00, REG_PROMSTAT}, prom_status, "prom status read");
        read_check({ADDR_MAIN, 8'h00, REG_PROMRES}, prom_result, "prom result read");
        read_check({ADDR_MAIN, 8'h00, REG_ETHRES}, eth_result, "eth result read");
        read_check(16'h0005, reg_rdata_ext, "unused offset read");

        // --------------------------------------------------------------
        // watchdog
        // --------------------------------------------------------------
        bus_write({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd2);
        check_value("wdog_period_led", wdog_period_led, 1'b1);
        check_value("wdog_period_status", wdog_period_status, 3'd2);
        read_check({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd2, "wdog code read");
        n = 0;
        while (!wdog_timeout && n < 200) begin
            @(negedge sysclk);
            n++;
        end
        if (!wdog_timeout) begin
            errors++;
            $display("watchdog timeout did not rise within 200 cycles");
        end else if (n + 1 != 2 * WDOG_UNIT) begin
            errors++;
            $display("watchdog timeout rose after %0d cycles instead of %0d",
                     n + 1, 2 * WDOG_UNIT);
        end
        read_check({ADDR_MAIN, 8'h00, REG_STATUS}, {8'h8A, 24'h0}, "status with timeout");
        wdog_clear = 1'b1;
        @(negedge sysclk);
        wdog_clear = 1'b0;
        check_value("wdog_timeout", wdog_timeout, 1'b0);  // dropped on the clear edge
        bus_write({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd0);
        check_value("wdog_period_led", wdog_period_led, 1'b0);
        check_value("wdog_period_status", wdog_period_status, 3'd0);
        for (n = 0; n < 5 * 2 * WDOG_UNIT; n++) begin   // five former periods
            check_value("wdog_timeout", wdog_timeout, 1'b0);
            @(negedge sysclk);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/host_bus_pkg.sv
rtl/write_bus_arbiter.sv
rtl/read_bus_select.sv
rtl/read_data_router.sv
rtl/board_regs.sv
rtl/fpga_bus_core.sv
verif/fpga_bus_core_assert.sv
verif/tb_fpga_bus_core.sv
